/* Makefile */
# Verilator build and run of the APB subsystem testbench
VERILATOR ?= verilator
TOP       ?= apb_subsystem_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/apb_sub_assertions.sv */
`timescale 1ns/1ps
// ------------------------------
// Bound at the subsystem top, where bridge handshake and slot selects meet
// ------------------------------
`include "apb_sub_consts.svh"

module apb_sub_assertions (
   input logic                   hclk,
   input logic                   rst,
   input logic                   psel_req,
   input logic                   penable,
   input logic                   sel_ready,
   input logic                   hready,
   input logic [1:0]             hresp,
   input logic [`APB_AW-1:0]     paddr,
   input logic [`SLOT_COUNT-1:0] slot_sel
);

   localparam logic [1:0] RESP_ERROR = 2'b01;

   // ------------------------------
   // APB phases
   // ------------------------------

   // ACCESS is entered only from SETUP
   a_penable_after_setup: assert property (@(posedge hclk) disable iff (rst)
      $rose(penable) |-> $past(psel_req && !penable))
      else $error("penable rose without a SETUP cycle before it");

   a_slot_onehot: assert property (@(posedge hclk) disable iff (rst)
      $onehot0(slot_sel))
      else $error("more than one slot selected");

   // Wait states keep the address still
   a_paddr_stable: assert property (@(posedge hclk) disable iff (rst)
      (penable && !sel_ready) |=> $stable(paddr))
      else $error("paddr changed during a wait state");

   // ------------------------------
   // AHB error response
   // ------------------------------
   a_err_first: assert property (@(posedge hclk) disable iff (rst)
      (hresp == RESP_ERROR && !hready) |=> (hresp == RESP_ERROR && hready))
      else $error("ERROR response not followed by its second cycle");

   a_err_second: assert property (@(posedge hclk) disable iff (rst)
      (hresp == RESP_ERROR && hready) |-> $past(hresp == RESP_ERROR && !hready))
      else $error("ERROR response with hready high lacks its first cycle");

endmodule

bind apb_subsystem apb_sub_assertions u_assertions (
   .hclk      (hclk),
   .rst       (rst),
   .psel_req  (psel_req),
   .penable   (penable),
   .sel_ready (sel_ready),
   .hready    (hready),
   .hresp     (hresp),
   .paddr     (paddr),
   .slot_sel  (slot_sel)
);

/* dv/apb_subsystem_tb.sv */
`timescale 1ns/1ps
// ------------------------------
// One AHB transfer at a time, hready_in tied high
// MAC slots are 16-word memories, ALUT checked against a table model
// ------------------------------
`include "apb_sub_consts.svh"

module apb_subsystem_tb
   import apb_sub_pkg::*;
();

   localparam int PERIOD      = 40;
   localparam int N_MAC       = 24;
   localparam int N_ERR       = 4;
   localparam int N_KEYS      = 5;
   localparam int MAX_WAIT    = 20;
   // Worst case about 7 transfers per ALUT command, 8 cycles per transfer
   localparam int XFER_BUDGET = N_MAC + N_ERR + 1 + 8 * (2 * N_KEYS + 30);
   localparam int WATCHDOG_NS = XFER_BUDGET * 8 * PERIOD;

   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [1:0] RESP_OKAY     = 2'b00;
   localparam logic [1:0] RESP_ERROR    = 2'b01;

   // DUT ports
   logic               hclk;
   logic               rst;
   logic               hsel;
   logic [`APB_AW-1:0] haddr;
   logic [1:0]         htrans;
   logic               hwrite;
   logic [`APB_DW-1:0] hwdata;
   logic               hready_in;
   wire  [`APB_DW-1:0] hrdata;
   wire                hready;
   wire  [1:0]         hresp;
   wire  [`APB_AW-1:0] paddr;
   wire                pwrite;
   wire                penable;
   wire  [`APB_DW-1:0] pwdata;
   wire  [3:0]         psel_v;
   logic [`APB_DW-1:0] prdata_mac [4];
   logic [3:0]         pready_v;

   // Run bookkeeping
   integer seed = 32'h74b5;
   int     errors;
   int     checks;
   int     last_low;
   logic   zero_wait;

   // MAC slave memories and the expected copy
   logic [31:0] mac_mem   [4][16];
   logic [31:0] model_mem [4][16];
   int          wait_left [4];

   // What the MAC side saw during the last transfer
   logic [3:0]  psel_seen;
   logic        penable_seen;
   logic [31:0] obs_paddr;
   logic [31:0] obs_pwdata;
   logic        obs_pwrite;
   int          obs_delay;

   // ALUT reference table
   logic        m_valid [`ALUT_DEPTH];
   logic [31:0] m_key   [`ALUT_DEPTH];
   logic [2:0]  m_port  [`ALUT_DEPTH];
   logic        exp_hit;
   logic        exp_full;
   logic [2:0]  exp_port;
   logic [31:0] key_list [9];

   apb_subsystem UUT (
      .hclk        (hclk),
      .rst         (rst),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .psel_mac0   (psel_v[0]),
      .psel_mac1   (psel_v[1]),
      .psel_mac2   (psel_v[2]),
      .psel_mac3   (psel_v[3]),
      .prdata_mac0 (prdata_mac[0]),
      .prdata_mac1 (prdata_mac[1]),
      .prdata_mac2 (prdata_mac[2]),
      .prdata_mac3 (prdata_mac[3]),
      .pready_mac0 (pready_v[0]),
      .pready_mac1 (pready_v[1]),
      .pready_mac2 (pready_v[2]),
      .pready_mac3 (pready_v[3])
   );

   initial begin
      hclk = 1'b0;
      forever #(PERIOD / 2) hclk = ~hclk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // ------------------------------
   // MAC slave models
   // ------------------------------
   initial begin
      forever begin
         @(negedge hclk);
         psel_seen    = psel_seen | psel_v;
         penable_seen = penable_seen | penable;
         for (int n = 0; n < 4; n++) begin
            if (psel_v[n] && !penable) begin
               // SETUP, pick this transfer's wait states
               wait_left[n]  = zero_wait ? 0 : ($random(seed) & 3);
               obs_delay     = wait_left[n];
               pready_v[n]   = 1'b0;
               prdata_mac[n] = mac_mem[n][paddr[5:2]];
            end else if (psel_v[n] && penable) begin
               obs_paddr  = paddr;
               obs_pwdata = pwdata;
               obs_pwrite = pwrite;
               if (pwrite) begin
                  mac_mem[n][paddr[5:2]] = pwdata;
               end
               if (wait_left[n] == 0) begin
                  pready_v[n] = 1'b1;
               end else begin
                  pready_v[n]  = 1'b0;
                  wait_left[n] = wait_left[n] - 1;
               end
            end else begin
               pready_v[n] = 1'b0;
            end
         end
      end
   end

   // Every word tagged with slot and index
   function automatic logic [31:0] fill_word(int n, int idx);
      return 32'h5A00_0000 | (32'(n) << 16) | (32'(idx) * 32'h0000_0101);
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   // ------------------------------
   // AHB master
   // ------------------------------

   // Starts and ends on a falling edge with hready high
   task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic [1:0] resp_first,
                           output logic [1:0] resp_last, output int low);
      hsel         = 1'b1;
      haddr        = addr;
      htrans       = HTRANS_NONSEQ;
      hwrite       = wr;
      psel_seen    = 4'b0;
      penable_seen = 1'b0;
      @(negedge hclk);
      // Data phase
      hsel       = 1'b0;
      htrans     = HTRANS_IDLE;
      hwdata     = wdata;
      resp_first = hresp;
      low        = 0;
      while (!hready && low < MAX_WAIT) begin
         low++;
         @(negedge hclk);
      end
      if (!hready) begin
         errors++;
         $display("AHB transfer to %h never completed", addr);
      end
      rdata     = hrdata;
      resp_last = hresp;
      last_low  = low;
   endtask

   task automatic mac_access(input int n, input int idx, input logic wr);
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic [1:0]  r0;
      logic [1:0]  r1;
      int          low;
      addr  = `SLOT1_BASE + 32'(n) * 32'h0001_0000 + 32'(idx) * 4;
      wdata = $random(seed);
      ahb_xfer(addr, wr, wdata, rdata, r0, r1, low);
      check_eq("hresp", 32'(r1), 32'(RESP_OKAY));
      check_eq("psel_mac", 32'(psel_seen), 32'(1) << n);
      check_eq("paddr", obs_paddr, addr);
      check_eq("pwrite", 32'(obs_pwrite), 32'(wr));
      // Two cycles plus one per wait state
      check_eq("hready low count", 32'(low), 32'(2 + obs_delay));
      if (wr) begin
         check_eq("pwdata", obs_pwdata, wdata);
         model_mem[n][idx] = wdata;
      end else begin
         check_eq("hrdata", rdata, model_mem[n][idx]);
      end
   endtask

   task automatic bad_access(input logic [31:0] addr, input logic wr);
      logic [31:0] rdata;
      logic [1:0]  r0;
      logic [1:0]  r1;
      int          low;
      ahb_xfer(addr, wr, $random(seed), rdata, r0, r1, low);
      check_eq("hresp", 32'(r0), 32'(RESP_ERROR));
      check_eq("hresp", 32'(r1), 32'(RESP_ERROR));
      check_eq("hready low count", 32'(low), 32'd1);
      check_eq("psel_mac", 32'(psel_seen), 32'd0);
      check_eq("penable", 32'(penable_seen), 32'd0);
   endtask

   // ------------------------------
   // ALUT access and model
   // ------------------------------
   task automatic alut_write(input logic [3:0] ofs, input logic [31:0] data);
      logic [31:0] rdata;
      logic [1:0]  r0;
      logic [1:0]  r1;
      int          low;
      ahb_xfer(`SLOT0_BASE | 32'(ofs), 1'b1, data, rdata, r0, r1, low);
      check_eq("hresp", 32'(r1), 32'(RESP_OKAY));
      check_eq("psel_mac", 32'(psel_seen), 32'd0);
   endtask

   task automatic alut_read(input logic [3:0] ofs, output logic [31:0] data);
      logic [1:0] r0;
      logic [1:0] r1;
      int         low;
      ahb_xfer(`SLOT0_BASE | 32'(ofs), 1'b0, 32'd0, data, r0, r1, low);
      check_eq("hresp", 32'(r1), 32'(RESP_OKAY));
   endtask

   function automatic void model_apply(alut_cmd_t cmd, logic [31:0] key, logic [2:0] port);
      int hit_idx;
      int free_idx;
      hit_idx  = -1;
      free_idx = -1;
      // Downward scan leaves the lowest index
      for (int i = `ALUT_DEPTH - 1; i >= 0; i--) begin
         if (m_valid[i] && m_key[i] == key) hit_idx = i;
         if (!m_valid[i]) free_idx = i;
      end
      exp_hit  = 1'b0;
      exp_full = 1'b0;
      case (cmd)
         ADD: begin
            if (hit_idx >= 0) begin
               m_port[hit_idx] = port;
            end else if (free_idx >= 0) begin
               m_valid[free_idx] = 1'b1;
               m_key[free_idx]   = key;
               m_port[free_idx]  = port;
            end else begin
               exp_full = 1'b1;
            end
         end
         LOOKUP: begin
            if (hit_idx >= 0) begin
               exp_hit  = 1'b1;
               exp_port = m_port[hit_idx];
            end
         end
         DELETE: begin
            if (hit_idx >= 0) m_valid[hit_idx] = 1'b0;
         end
         CLEAR: begin
            for (int i = 0; i < `ALUT_DEPTH; i++) m_valid[i] = 1'b0;
         end
         default: begin
         end
      endcase
   endfunction

   task automatic alut_cmd(input alut_cmd_t cmd, input logic [31:0] key, input logic [2:0] port);
      logic [31:0] stat;
      int          polls;
      alut_write(`ALUT_KEY_OFS, key);
      alut_write(`ALUT_PORT_OFS, 32'(port));
      alut_write(`ALUT_CMD_OFS, 32'(cmd));
      model_apply(cmd, key, port);
      // Scans still run at the first poll, CLEAR is already done
      alut_read(`ALUT_STAT_OFS, stat);
      check_eq("alut busy", 32'(stat[0]), 32'(cmd != CLEAR));
      polls = 0;
      while (stat[0] && polls < MAX_WAIT) begin
         polls++;
         alut_read(`ALUT_STAT_OFS, stat);
      end
      if (stat[0]) begin
         errors++;
         $display("ALUT stayed busy after command %s", cmd.name());
      end
      check_eq("alut hit", 32'(stat[1]), 32'(exp_hit));
      check_eq("alut full", 32'(stat[2]), 32'(exp_full));
      if (exp_hit) begin
         check_eq("alut port", 32'(stat[6:4]), 32'(exp_port));
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic [31:0] base;
      logic [31:0] addr;
      errors    = 0;
      checks    = 0;
      hsel      = 1'b0;
      haddr     = '0;
      htrans    = HTRANS_IDLE;
      hwrite    = 1'b0;
      hwdata    = '0;
      hready_in = 1'b1;
      zero_wait = 1'b0;
      pready_v  = 4'b0;
      rst       = 1'b1;
      for (int n = 0; n < 4; n++) begin
         prdata_mac[n] = '0;
         wait_left[n]  = 0;
         for (int i = 0; i < 16; i++) begin
            mac_mem[n][i]   = fill_word(n, i);
            model_mem[n][i] = fill_word(n, i);
         end
      end
      for (int i = 0; i < `ALUT_DEPTH; i++) m_valid[i] = 1'b0;
      repeat (2) @(posedge hclk);
      @(negedge hclk);
      rst = 1'b0;

      // Idle bus after reset
      check_eq("hready", 32'(hready), 32'd1);
      check_eq("hresp", 32'(hresp), 32'(RESP_OKAY));
      check_eq("psel_mac", 32'(psel_v), 32'd0);
      check_eq("penable", 32'(penable), 32'd0);

      // Random MAC traffic under random wait states
      for (int t = 0; t < N_MAC; t++) begin
         mac_access($random(seed) & 3, ($random(seed) >>> 4) & 15, $random(seed) & 1);
      end

      // Unmapped addresses on both sides of the map
      for (int t = 0; t < N_ERR; t++) begin
         case ($random(seed) & 3)
            0: addr = 32'h00A5_0000 | ($random(seed) & 32'h0000_FFFC);
            1: addr = 32'h0000_1000 | ($random(seed) & 32'h0000_0FFC);
            2: addr = 32'h009F_FFFC;
            default: addr = 32'hFFFF_FFFC;
         endcase
         bad_access(addr, t[0]);
      end

      // Zero wait state read
      zero_wait = 1'b1;
      mac_access(2, 5, 1'b0);
      check_eq("hready low count", 32'(last_low), 32'd2);
      zero_wait = 1'b0;

      // ALUT fill and lookups
      alut_cmd(CLEAR, 32'd0, 3'd0);
      for (int i = 0; i < N_KEYS; i++) begin
         key_list[i] = $random(seed);
         alut_cmd(ADD, key_list[i], 3'($random(seed)));
      end
      for (int i = 0; i < N_KEYS; i++) alut_cmd(LOOKUP, key_list[i], 3'd0);
      for (int i = 0; i < 3; i++) alut_cmd(LOOKUP, $random(seed), 3'd0);
      alut_cmd(DELETE, key_list[1], 3'd0);
      alut_cmd(LOOKUP, key_list[1], 3'd0);

      // Nine distinct keys overflow the table
      alut_cmd(CLEAR, 32'd0, 3'd0);
      base = $random(seed) & 32'hFFFF_FFF0;
      for (int i = 0; i < 9; i++) begin
         key_list[i] = base | 32'(i);
         alut_cmd(ADD, key_list[i], 3'(i));
      end
      alut_cmd(CLEAR, 32'd0, 3'd0);
      for (int i = 0; i < 9; i++) alut_cmd(LOOKUP, key_list[i], 3'd0);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* include/apb_sub_consts.svh */
// ------------------------------
// Fixed slot map and ALUT layout, so slot ranges change only here
// Word access only, offsets decoded on address bits 3:0
// ------------------------------
`ifndef APB_SUB_CONSTS_SVH
`define APB_SUB_CONSTS_SVH

// Bus widths
`define APB_AW 32
`define APB_DW 32

// Number of APB slots, ALUT plus four MACs
`define SLOT_COUNT 5

// Inclusive 64 KB slot ranges
`define SLOT0_BASE 32'h00A0_0000
`define SLOT0_LAST 32'h00A0_FFFF
`define SLOT1_BASE 32'h00A1_0000
`define SLOT1_LAST 32'h00A1_FFFF
`define SLOT2_BASE 32'h00A2_0000
`define SLOT2_LAST 32'h00A2_FFFF
`define SLOT3_BASE 32'h00A3_0000
`define SLOT3_LAST 32'h00A3_FFFF
`define SLOT4_BASE 32'h00A4_0000
`define SLOT4_LAST 32'h00A4_FFFF

// ALUT register offsets
`define ALUT_KEY_OFS  4'h0
`define ALUT_PORT_OFS 4'h4
`define ALUT_CMD_OFS  4'h8
`define ALUT_STAT_OFS 4'hC

// ALUT table shape
`define ALUT_DEPTH 8
`define ALUT_PW    3

`endif

/* logic/ahb_apb_bridge.sv */
`timescale 1ns/1ps
// ------------------------------
// Single beats only, bursts split into separate transfers
// APB shares hclk, hsize/hprot/hburst not supported
// ------------------------------
`include "apb_sub_consts.svh"

module ahb_apb_bridge
   import apb_sub_pkg::*;
(
   input  logic               hclk,
   input  logic               rst,
   // AHB-lite slave side
   input  logic               hsel,
   input  logic [`APB_AW-1:0] haddr,
   input  logic [1:0]         htrans,
   input  logic               hwrite,
   input  logic [`APB_DW-1:0] hwdata,
   input  logic               hready_in,
   output logic [`APB_DW-1:0] hrdata,
   output logic               hready,
   output logic [1:0]         hresp,
   // APB request bus
   apb_bus_if.bridge          bus,
   // Decoder handshake
   output logic               psel_req,
   input  logic               map_hit,
   input  logic [`APB_DW-1:0] sel_rdata,
   input  logic               sel_ready
);

   localparam logic [1:0] HRESP_OKAY  = 2'b00;
   localparam logic [1:0] HRESP_ERROR = 2'b01;

   bridge_state_t      state;
   bridge_state_t      state_nxt;
   logic               accept;
   logic [`APB_AW-1:0] addr_q;
   logic               write_q;
   logic [`APB_DW-1:0] wdata_q;
   logic [`APB_DW-1:0] rdata_q;

   // ------------------------------
   // AHB address phase
   // ------------------------------

   // NONSEQ or SEQ beat while the bus and this slave are ready
   // BUSY and IDLE fail the htrans[1] test
   assign accept = hsel & htrans[1] & hready_in & hready;

   // Only IDLE, DONE and ERR2 present hready high
   assign hready = (state == IDLE) || (state == DONE) || (state == ERR2);
   assign hresp  = ((state == ERR1) || (state == ERR2)) ? HRESP_ERROR : HRESP_OKAY;
   assign hrdata = rdata_q;

   // ------------------------------
   // FSM
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, DONE, ERR2: begin
            // Back to back beat can start straight from DONE or ERR2
            if (accept) begin
               if (map_hit) begin
                  state_nxt = SETUP;
               end else begin
                  state_nxt = ERR1;
               end
            end else begin
               state_nxt = IDLE;
            end
         end
         SETUP: begin
            state_nxt = ACCESS;
         end
         ACCESS: begin
            // Wait states from the selected slot
            if (sel_ready) begin
               state_nxt = DONE;
            end
         end
         ERR1: begin
            state_nxt = ERR2;
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge hclk) begin
      if (rst) begin
         state   <= IDLE;
         addr_q  <= '0;
         write_q <= 1'b0;
      end else begin
         state <= state_nxt;
         // Address and direction held for the whole APB transfer
         if (accept) begin
            addr_q  <= haddr;
            write_q <= hwrite;
         end
      end
   end

   // Data holding registers
   always_ff @(posedge hclk) begin
      // hwdata is valid in the AHB data phase, which is SETUP
      if (state == SETUP) begin
         wdata_q <= hwdata;
      end
      // Read data shown during DONE
      if ((state == ACCESS) && sel_ready && !write_q) begin
         rdata_q <= sel_rdata;
      end
   end

   // ------------------------------
   // APB request
   // ------------------------------

   // psel only in SETUP and ACCESS
   assign psel_req = (state == SETUP) || (state == ACCESS);
   assign bus.penable = (state == ACCESS);
   assign bus.pwrite  = write_q;

   // Live haddr during acceptance so the decoder resolves map_hit that cycle
   // psel is low then, so no slave sees the change
   assign bus.paddr = accept ? haddr : addr_q;

   // Pass hwdata straight through in SETUP, then hold it
   assign bus.pwdata = (state == SETUP) ? hwdata : wdata_q;

endmodule

/* logic/alut_regs.sv */
`timescale 1ns/1ps
// ------------------------------
// Flags hit/full reflect the last command only
// Offsets alias every 16 bytes, writes ignored while busy
// ------------------------------
`include "apb_sub_consts.svh"

module alut_regs
   import apb_sub_pkg::*;
(
   input  logic               hclk,
   input  logic               rst,
   apb_bus_if.slave           bus,
   input  logic               psel,
   output logic [`APB_DW-1:0] prdata
);

   localparam int IW = $clog2(`ALUT_DEPTH);

   // Software registers
   logic [`APB_DW-1:0]  key_q;
   logic [`ALUT_PW-1:0] port_q;
   alut_cmd_t           cmd_q;
   logic                busy_q;
   logic                hit_q;
   logic                full_q;
   logic [`ALUT_PW-1:0] res_port_q;
   // Table
   logic [`ALUT_DEPTH-1:0] valid_q;
   logic [`APB_DW-1:0]     keys_q  [`ALUT_DEPTH];
   logic [`ALUT_PW-1:0]    ports_q [`ALUT_DEPTH];
   // Scan state
   logic [IW-1:0] idx_q;
   logic          matched_q;
   logic          free_found_q;
   logic [IW-1:0] free_idx_q;
   // Decode
   logic          wr_en;
   alut_cmd_t     cmd_in;
   logic          cmd_start;
   logic          cur_match;
   logic          cur_free;
   logic          last;
   logic          mem_we;
   logic [IW-1:0] mem_idx;
   logic          add_full;

   assign wr_en  = psel & bus.penable & bus.pwrite;
   assign cmd_in = alut_cmd_t'(bus.pwdata[2:0]);
   // NOP and unknown codes do not start a scan
   assign cmd_start = wr_en && !busy_q && (bus.paddr[3:0] == `ALUT_CMD_OFS) &&
                      (cmd_in inside {ADD, LOOKUP, DELETE, CLEAR});

   // Entry under the scan pointer
   assign cur_match = valid_q[idx_q] && (keys_q[idx_q] == key_q);
   assign cur_free  = !valid_q[idx_q];
   assign last      = (idx_q == IW'(`ALUT_DEPTH - 1));

   // ------------------------------
   // ADD write decision
   // ------------------------------
   always_comb begin
      mem_we   = 1'b0;
      mem_idx  = idx_q;
      add_full = 1'b0;
      if (busy_q && (cmd_q == ADD) && !matched_q) begin
         if (cur_match) begin
            // Existing key gets the new port in place
            mem_we = 1'b1;
         end else if (last) begin
            // End of scan, lowest free slot wins
            if (free_found_q) begin
               mem_we  = 1'b1;
               mem_idx = free_idx_q;
            end else if (cur_free) begin
               mem_we = 1'b1;
            end else begin
               add_full = 1'b1;
            end
         end
      end
   end

   // Key and port storage
   always_ff @(posedge hclk) begin
      if (mem_we) begin
         keys_q[mem_idx]  <= key_q;
         ports_q[mem_idx] <= port_q;
      end
   end

   // ------------------------------
   // Registers and scan engine
   // ------------------------------
   always_ff @(posedge hclk) begin
      if (rst) begin
         key_q        <= '0;
         port_q       <= '0;
         cmd_q        <= NOP;
         busy_q       <= 1'b0;
         hit_q        <= 1'b0;
         full_q       <= 1'b0;
         res_port_q   <= '0;
         valid_q      <= '0;
         idx_q        <= '0;
         matched_q    <= 1'b0;
         free_found_q <= 1'b0;
         free_idx_q   <= '0;
      end else if (!busy_q) begin
         if (wr_en && (bus.paddr[3:0] == `ALUT_KEY_OFS)) begin
            key_q <= bus.pwdata;
         end
         if (wr_en && (bus.paddr[3:0] == `ALUT_PORT_OFS)) begin
            port_q <= bus.pwdata[`ALUT_PW-1:0];
         end
         // Busy from the next cycle on
         if (cmd_start) begin
            cmd_q        <= cmd_in;
            busy_q       <= 1'b1;
            idx_q        <= '0;
            matched_q    <= 1'b0;
            free_found_q <= 1'b0;
            hit_q        <= 1'b0;
            full_q       <= 1'b0;
         end
      end else begin
         case (cmd_q)
            ADD: begin
               if (cur_match) begin
                  matched_q <= 1'b1;
               end
               if (cur_free && !free_found_q) begin
                  free_found_q <= 1'b1;
                  free_idx_q   <= idx_q;
               end
               if (mem_we) begin
                  valid_q[mem_idx] <= 1'b1;
               end
               if (add_full) begin
                  full_q <= 1'b1;
               end
            end
            LOOKUP: begin
               if (cur_match) begin
                  hit_q      <= 1'b1;
                  res_port_q <= ports_q[idx_q];
               end
            end
            DELETE: begin
               if (cur_match) begin
                  valid_q[idx_q] <= 1'b0;
               end
            end
            default: begin
               // CLEAR in one cycle, flags already low from the start
               valid_q <= '0;
            end
         endcase
         idx_q <= idx_q + 1'b1;
         if (last || (cmd_q == CLEAR)) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Read mux
   // STATUS bit 0 busy, bit 1 hit, bit 2 full, bits 6:4 result port
   always_comb begin
      case (bus.paddr[3:0])
         `ALUT_KEY_OFS:  prdata = key_q;
         `ALUT_PORT_OFS: prdata = {{(`APB_DW - `ALUT_PW){1'b0}}, port_q};
         `ALUT_CMD_OFS:  prdata = {{(`APB_DW - 3){1'b0}}, cmd_q};
         `ALUT_STAT_OFS: prdata = {{(`APB_DW - 7){1'b0}}, res_port_q, 1'b0,
                                   full_q, hit_q, busy_q};
         default:        prdata = '0;
      endcase
   end

endmodule

/* logic/apb_bus_if.sv */
`timescale 1ns/1ps
// ------------------------------
// Shared APB request lines only
// psel and the return path stay per slot
// ------------------------------
`include "apb_sub_consts.svh"

interface apb_bus_if;

   // Request driven by the bridge
   logic [`APB_AW-1:0] paddr;
   logic               pwrite;
   logic [`APB_DW-1:0] pwdata;
   logic               penable;

   // Bridge side drives the request
   modport bridge (
      output paddr,
      output pwrite,
      output pwdata,
      output penable
   );

   // Decoder and ALUT only observe it
   modport slave (
      input paddr,
      input pwrite,
      input pwdata,
      input penable
   );

endinterface

/* logic/apb_slot_decoder.sv */
`timescale 1ns/1ps
// ------------------------------
// Fixed five slot map, slot 0 is always ready
// ------------------------------
`include "apb_sub_consts.svh"

module apb_slot_decoder (
   apb_bus_if.slave                 bus,
   input  logic                     psel_req,
   output logic                     map_hit,
   output logic [`SLOT_COUNT-1:0]   slot_sel,
   // Return path from the slots
   input  logic [`APB_DW-1:0]       alut_rdata,
   input  logic [`APB_DW-1:0]       prdata_mac0,
   input  logic [`APB_DW-1:0]       prdata_mac1,
   input  logic [`APB_DW-1:0]       prdata_mac2,
   input  logic [`APB_DW-1:0]       prdata_mac3,
   input  logic                     pready_mac0,
   input  logic                     pready_mac1,
   input  logic                     pready_mac2,
   input  logic                     pready_mac3,
   output logic [`APB_DW-1:0]       sel_rdata,
   output logic                     sel_ready
);

   // Slot ranges, index equals slot number
   localparam logic [`SLOT_COUNT-1:0][`APB_AW-1:0] SLOT_BASE = {
      `SLOT4_BASE, `SLOT3_BASE, `SLOT2_BASE, `SLOT1_BASE, `SLOT0_BASE
   };
   localparam logic [`SLOT_COUNT-1:0][`APB_AW-1:0] SLOT_LAST = {
      `SLOT4_LAST, `SLOT3_LAST, `SLOT2_LAST, `SLOT1_LAST, `SLOT0_LAST
   };

   logic [`SLOT_COUNT-1:0]              hit;
   logic [`SLOT_COUNT-1:0][`APB_DW-1:0] rdata_arr;
   logic [`SLOT_COUNT-1:0]              ready_arr;

   // Range compare per slot
   always_comb begin
      for (int i = 0; i < `SLOT_COUNT; i++) begin
         hit[i] = (bus.paddr >= SLOT_BASE[i]) && (bus.paddr <= SLOT_LAST[i]);
      end
   end

   // Ranges are disjoint so hit is one-hot or zero
   assign map_hit  = |hit;
   assign slot_sel = psel_req ? hit : '0;

   // ALUT never stalls
   assign rdata_arr = {prdata_mac3, prdata_mac2, prdata_mac1, prdata_mac0, alut_rdata};
   assign ready_arr = {pready_mac3, pready_mac2, pready_mac1, pready_mac0, 1'b1};

   // Return mux on the gated select
   always_comb begin
      sel_rdata = '0;
      sel_ready = 1'b0;
      for (int i = 0; i < `SLOT_COUNT; i++) begin
         if (slot_sel[i]) begin
            sel_rdata = rdata_arr[i];
            sel_ready = ready_arr[i];
         end
      end
   end

endmodule

/* logic/apb_sub_pkg.sv */
// ------------------------------
// Types shared by bridge and ALUT
// ------------------------------
package apb_sub_pkg;

   // Bridge FSM
   // IDLE waits for an address phase, ERR1/ERR2 form the AHB error response
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      SETUP  = 3'd1,
      ACCESS = 3'd2,
      DONE   = 3'd3,
      ERR1   = 3'd4,
      ERR2   = 3'd5
   } bridge_state_t;

   // ALUT command codes as written to CMD bits 2:0
   typedef enum logic [2:0] {
      NOP    = 3'd0,
      ADD    = 3'd1,
      LOOKUP = 3'd2,
      DELETE = 3'd3,
      CLEAR  = 3'd4
   } alut_cmd_t;

endpackage

/* logic/apb_subsystem.sv */
`timescale 1ns/1ps
// ------------------------------
// APB runs on hclk, MAC blocks share the request lines
// ------------------------------
`include "apb_sub_consts.svh"

module apb_subsystem (
   // AHB-lite slave port
   input  logic               hclk,
   input  logic               rst,
   input  logic               hsel,
   input  logic [`APB_AW-1:0] haddr,
   input  logic [1:0]         htrans,
   input  logic               hwrite,
   input  logic [`APB_DW-1:0] hwdata,
   input  logic               hready_in,
   output logic [`APB_DW-1:0] hrdata,
   output logic               hready,
   output logic [1:0]         hresp,
   // Shared APB request
   output logic [`APB_AW-1:0] paddr,
   output logic               pwrite,
   output logic               penable,
   output logic [`APB_DW-1:0] pwdata,
   // MAC slots 1 to 4
   output logic               psel_mac0,
   output logic               psel_mac1,
   output logic               psel_mac2,
   output logic               psel_mac3,
   input  logic [`APB_DW-1:0] prdata_mac0,
   input  logic [`APB_DW-1:0] prdata_mac1,
   input  logic [`APB_DW-1:0] prdata_mac2,
   input  logic [`APB_DW-1:0] prdata_mac3,
   input  logic               pready_mac0,
   input  logic               pready_mac1,
   input  logic               pready_mac2,
   input  logic               pready_mac3
);

   apb_bus_if apb ();

   logic                   psel_req;
   logic                   map_hit;
   logic [`SLOT_COUNT-1:0] slot_sel;
   logic [`APB_DW-1:0]     alut_rdata;
   logic [`APB_DW-1:0]     sel_rdata;
   logic                   sel_ready;

   ahb_apb_bridge u_bridge (
      .hclk      (hclk),
      .rst       (rst),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .bus       (apb.bridge),
      .psel_req  (psel_req),
      .map_hit   (map_hit),
      .sel_rdata (sel_rdata),
      .sel_ready (sel_ready)
   );

   apb_slot_decoder u_decoder (
      .bus         (apb.slave),
      .psel_req    (psel_req),
      .map_hit     (map_hit),
      .slot_sel    (slot_sel),
      .alut_rdata  (alut_rdata),
      .prdata_mac0 (prdata_mac0),
      .prdata_mac1 (prdata_mac1),
      .prdata_mac2 (prdata_mac2),
      .prdata_mac3 (prdata_mac3),
      .pready_mac0 (pready_mac0),
      .pready_mac1 (pready_mac1),
      .pready_mac2 (pready_mac2),
      .pready_mac3 (pready_mac3),
      .sel_rdata   (sel_rdata),
      .sel_ready   (sel_ready)
   );

   // Slot 0
   alut_regs u_alut (
      .hclk   (hclk),
      .rst    (rst),
      .bus    (apb.slave),
      .psel   (slot_sel[0]),
      .prdata (alut_rdata)
   );

   // Request lines out to the MAC blocks
   assign paddr   = apb.paddr;
   assign pwrite  = apb.pwrite;
   assign penable = apb.penable;
   assign pwdata  = apb.pwdata;

   // Slot n+1 is MAC n
   assign psel_mac0 = slot_sel[1];
   assign psel_mac1 = slot_sel[2];
   assign psel_mac2 = slot_sel[3];
   assign psel_mac3 = slot_sel[4];

endmodule

/* project.f */
+incdir+include
logic/apb_sub_pkg.sv
logic/apb_bus_if.sv
logic/ahb_apb_bridge.sv
logic/apb_slot_decoder.sv
logic/alut_regs.sv
logic/apb_subsystem.sv
dv/apb_sub_assertions.sv
dv/apb_subsystem_tb.sv
